// File: common/nand_cpu_pkg.sv
`default_nettype none

package nand_cpu_pkg;

    localparam int PC_SIZE = 32;
    localparam logic [PC_SIZE-1:0] RESET_PC = 32'h0000_0000;

    // ========================================
    // enums
    // ========================================

    // direction predictor selection
    typedef enum logic {
        GSHARE
    } predictor_type_e;

    typedef enum logic {
        BR_COND,
        BR_JUMP
    } branch_kind_e;

    // ========================================
    // structs
    // ========================================

    // resolved branch from the back end
    typedef struct packed {
        logic [PC_SIZE-1:0] pc;
        logic [PC_SIZE-1:0] target;
        branch_kind_e       kind;
        logic               taken;
        logic               mispredict;
        logic [PC_SIZE-1:0] next_pc;
    } branch_feedback_t;

    // lookup sent from the predictor wrapper to the direction predictor
    typedef struct packed {
        logic [PC_SIZE-1:0] pc;
        logic [PC_SIZE-1:0] target;
        logic               ps;
    } branch_request_t;

    // one fetch toward the decode queue
    typedef struct packed {
        logic [PC_SIZE-1:0] pc;
        logic               pred_override;
        logic [PC_SIZE-1:0] pred_target;
    } fetch_packet_t;

endpackage

`default_nettype wire

// File: branch_predictor/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic                             clk,
    input  logic                             n_rst,

    input  logic [nand_cpu_pkg::PC_SIZE-1:0] pc,

    output logic                             hit,
    output nand_cpu_pkg::branch_kind_e       kind,
    output logic [nand_cpu_pkg::PC_SIZE-1:0] target,

    input  logic                             feedback_valid,
    input  nand_cpu_pkg::branch_feedback_t   feedback
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = nand_cpu_pkg::PC_SIZE - IDX_W - 2;

    logic [BTB_ENTRIES-1:0]             valid_q;
    nand_cpu_pkg::branch_kind_e         kind_q   [BTB_ENTRIES];
    logic [TAG_W-1:0]                   tag_q    [BTB_ENTRIES];
    logic [nand_cpu_pkg::PC_SIZE-1:0]   target_q [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    // index sits right above the word offset, tag takes the rest
    assign rd_idx = pc[IDX_W+1:2];
    assign rd_tag = pc[nand_cpu_pkg::PC_SIZE-1:IDX_W+2];
    assign wr_idx = feedback.pc[IDX_W+1:2];
    assign wr_tag = feedback.pc[nand_cpu_pkg::PC_SIZE-1:IDX_W+2];

    // ========================================
    // lookup
    // ========================================
    assign hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign kind   = kind_q[rd_idx];
    assign target = target_q[rd_idx];

    // ========================================
    // update
    // ========================================
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
        end else if (feedback_valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // taken or not, the resolved branch replaces whatever was there
    always_ff @(posedge clk) begin
        if (feedback_valid) begin
            kind_q[wr_idx]   <= feedback.kind;
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= feedback.target;
        end
    end

    // back end must only ever resolve word-aligned branches
    assert property (@(posedge clk) disable iff (!n_rst)
        feedback_valid |-> (feedback.pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: branch_predictor/branch_predictor_gshare.sv
`default_nettype none

module branch_predictor_gshare #(
    parameter int INDEX_SIZE = 6
) (
    input  logic                           clk,
    input  logic                           n_rst,

    input  nand_cpu_pkg::branch_request_t  request,
    input  logic                           cond_hit,

    output logic                           taken,

    input  logic                           feedback_valid,
    input  nand_cpu_pkg::branch_feedback_t feedback
);

    localparam int TABLE_SIZE = 2 ** INDEX_SIZE;

    logic [INDEX_SIZE-1:0] history;
    logic [INDEX_SIZE-1:0] index;
    logic [INDEX_SIZE-1:0] fb_index;
    logic [1:0]            pht [TABLE_SIZE];

    // hash of global history with the word address
    assign index    = history ^ request.pc[INDEX_SIZE+1:2];
    assign fb_index = history ^ feedback.pc[INDEX_SIZE+1:2];
    assign taken    = pht[index][1];

    // ========================================
    // history and counters
    // ========================================
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            history <= '0;
            // weakly not taken
            for (int i = 0; i < TABLE_SIZE; i++) begin
                pht[i] <= 2'b01;
            end
        end else begin
            // speculative update, only for issued conditional hits
            if (request.ps && cond_hit) begin
                history <= {history[INDEX_SIZE-2:0], taken};
            end
            if (feedback_valid) begin
                if (feedback.taken) begin
                    if (pht[fb_index] != 2'b11) begin
                        pht[fb_index] <= pht[fb_index] + 2'b01;
                    end
                end else if (pht[fb_index] != 2'b00) begin
                    pht[fb_index] <= pht[fb_index] - 2'b01;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: branch_predictor/branch_predictor.sv
`default_nettype none

module branch_predictor #(
    parameter nand_cpu_pkg::predictor_type_e PREDICTOR   = nand_cpu_pkg::GSHARE,
    parameter int                            BTB_ENTRIES = 16,
    parameter int                            INDEX_SIZE  = 6
) (
    input  logic                             clk,
    input  logic                             n_rst,

    input  logic [nand_cpu_pkg::PC_SIZE-1:0] pc,
    input  logic                             ps,

    output logic                             pc_override,
    output logic [nand_cpu_pkg::PC_SIZE-1:0] target,

    input  logic                             feedback_valid,
    input  nand_cpu_pkg::branch_feedback_t   feedback
);

    logic                          hit;
    nand_cpu_pkg::branch_kind_e    kind;
    logic                          cond_hit;
    logic                          taken;
    nand_cpu_pkg::branch_request_t request;

    branch_target_buffer #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_btb (
        .clk,
        .n_rst,
        .pc,
        .hit,
        .kind,
        .target,
        .feedback_valid,
        .feedback
    );

    always_comb begin
        request.pc     = pc;
        request.target = target;
        request.ps     = ps;
    end

    assign cond_hit = hit && (kind == nand_cpu_pkg::BR_COND);

    // jumps always redirect, conditionals only when predicted taken
    assign pc_override = hit && ((kind == nand_cpu_pkg::BR_JUMP) || taken);

    generate
        case (PREDICTOR)
            nand_cpu_pkg::GSHARE: begin : g_gshare
                branch_predictor_gshare #(
                    .INDEX_SIZE(INDEX_SIZE)
                ) u_gshare (
                    .clk,
                    .n_rst,
                    .request,
                    .cond_hit,
                    .taken,
                    .feedback_valid,
                    .feedback
                );
            end
        endcase
    endgenerate

endmodule

`default_nettype wire

// File: verilog/fetch_pc_gen.sv
`default_nettype none

module fetch_pc_gen #(
    parameter int FETCH_CREDITS = 4
) (
    input  logic                             clk,
    input  logic                             n_rst,

    input  logic                             feedback_valid,
    input  nand_cpu_pkg::branch_feedback_t   feedback,
    input  logic                             credit_return,

    input  logic                             pc_override,
    input  logic [nand_cpu_pkg::PC_SIZE-1:0] pred_target,

    output logic [nand_cpu_pkg::PC_SIZE-1:0] pc,
    output logic                             fetch_valid,
    output nand_cpu_pkg::fetch_packet_t      fetch
);

    localparam int CREDIT_W = $clog2(FETCH_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] MAX_CREDITS = CREDIT_W'(FETCH_CREDITS);

    logic [CREDIT_W-1:0]              credits;
    logic                             started;
    logic                             redirect;
    logic [nand_cpu_pkg::PC_SIZE-1:0] next_pc;

    assign fetch_valid = started && (credits != '0);
    assign redirect    = feedback_valid && feedback.mispredict;

    // ========================================
    // next pc
    // ========================================
    always_comb begin
        if (redirect) begin
            next_pc = feedback.next_pc;
        end else if (pc_override) begin
            next_pc = pred_target;
        end else begin
            next_pc = pc + nand_cpu_pkg::PC_SIZE'(4);
        end
    end

    // a redirect loads even when stalled on credits
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            pc      <= nand_cpu_pkg::RESET_PC;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (redirect || fetch_valid) begin
                pc <= next_pc;
            end
        end
    end

    // ========================================
    // credits
    // ========================================
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            credits <= MAX_CREDITS;
        end else begin
            case ({fetch_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_comb begin
        fetch.pc            = pc;
        fetch.pred_override = pc_override;
        fetch.pred_target   = pred_target;
    end

    assert property (@(posedge clk) disable iff (!n_rst) credits <= MAX_CREDITS);

    // nothing outstanding, so nothing to give back
    assert property (@(posedge clk) disable iff (!n_rst)
        credit_return |-> (credits != MAX_CREDITS));

endmodule

`default_nettype wire

// File: verilog/fetch_frontend.sv
`default_nettype none

module fetch_frontend #(
    parameter nand_cpu_pkg::predictor_type_e PREDICTOR     = nand_cpu_pkg::GSHARE,
    parameter int                            BTB_ENTRIES   = 16,
    parameter int                            INDEX_SIZE    = 6,
    parameter int                            FETCH_CREDITS = 4
) (
    input  logic                           clk,
    input  logic                           n_rst,

    input  logic                           feedback_valid,
    input  nand_cpu_pkg::branch_feedback_t feedback,

    input  logic                           credit_return,

    output logic                           fetch_valid,
    output nand_cpu_pkg::fetch_packet_t    fetch
);

    logic [nand_cpu_pkg::PC_SIZE-1:0] pc;
    logic                             pc_override;
    logic [nand_cpu_pkg::PC_SIZE-1:0] pred_target;

    fetch_pc_gen #(
        .FETCH_CREDITS(FETCH_CREDITS)
    ) u_pc_gen (
        .clk,
        .n_rst,
        .feedback_valid,
        .feedback,
        .credit_return,
        .pc_override,
        .pred_target,
        .pc,
        .fetch_valid,
        .fetch
    );

    // predictor sees the held pc, ps marks a fetch issued this cycle
    branch_predictor #(
        .PREDICTOR  (PREDICTOR),
        .BTB_ENTRIES(BTB_ENTRIES),
        .INDEX_SIZE (INDEX_SIZE)
    ) u_predictor (
        .clk,
        .n_rst,
        .pc            (pc),
        .ps            (fetch_valid),
        .pc_override   (pc_override),
        .target        (pred_target),
        .feedback_valid(feedback_valid),
        .feedback      (feedback)
    );

endmodule

`default_nettype wire

// File: verification/fetch_frontend_tb.sv
`default_nettype none

module fetch_frontend_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int BTB_ENTRIES   = 16;
    localparam int INDEX_SIZE    = 6;
    localparam int FETCH_CREDITS = 4;
    localparam int BTB_IDX_W     = $clog2(BTB_ENTRIES);
    localparam int SCRIPT_CYCLES = 400;

    localparam logic [31:0] JUMP_PC     = 32'h0000_00c0;
    localparam logic [31:0] JUMP_TGT    = 32'h0000_1000;
    localparam logic [31:0] COND_PC     = 32'h0000_2010;
    localparam logic [31:0] COND_TGT    = 32'h0000_2000;
    localparam logic [31:0] OTHER_PC    = 32'h0000_0808;
    localparam logic [31:0] REDIRECT_PC = 32'h0000_3000;

    logic                           clk;
    logic                           n_rst;
    logic                           feedback_valid;
    nand_cpu_pkg::branch_feedback_t feedback;
    logic                           credit_return;
    logic                           fetch_valid;
    nand_cpu_pkg::fetch_packet_t    fetch;

    // consumer state
    integer seed = 32'hc4b7194d;
    int     tick;
    int     due_q[$];
    int     last_due;
    int     outstanding;
    logic   hold;

    // reference model state
    logic [31:0]                m_pc;
    logic                       m_started;
    int                         m_credits;
    logic                       m_btb_valid  [BTB_ENTRIES];
    nand_cpu_pkg::branch_kind_e m_btb_kind   [BTB_ENTRIES];
    logic [31:0]                m_btb_pc     [BTB_ENTRIES];
    logic [31:0]                m_btb_target [BTB_ENTRIES];
    logic [INDEX_SIZE-1:0]      m_hist;
    logic [1:0]                 m_ctr        [2**INDEX_SIZE];

    logic [BTB_IDX_W-1:0]  e_btb_idx;
    logic [BTB_IDX_W-1:0]  e_fb_btb_idx;
    logic [INDEX_SIZE-1:0] e_gidx;
    logic [INDEX_SIZE-1:0] e_fb_gidx;
    logic                  e_hit;
    logic                  e_cond_hit;
    logic                  e_taken;
    logic                  e_override;
    logic                  e_valid;
    logic                  e_redirect;
    logic [31:0]           e_target;
    logic [31:0]           e_next_pc;

    fetch_frontend #(
        .PREDICTOR    (nand_cpu_pkg::GSHARE),
        .BTB_ENTRIES  (BTB_ENTRIES),
        .INDEX_SIZE   (INDEX_SIZE),
        .FETCH_CREDITS(FETCH_CREDITS)
    ) u_dut (
        .clk,
        .n_rst,
        .feedback_valid,
        .feedback,
        .credit_return,
        .fetch_valid,
        .fetch
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================
    // reference model
    // ========================================
    always_comb begin
        e_btb_idx    = m_pc[BTB_IDX_W+1:2];
        e_fb_btb_idx = feedback.pc[BTB_IDX_W+1:2];
        e_hit        = m_btb_valid[e_btb_idx] && (m_btb_pc[e_btb_idx] == m_pc);
        e_cond_hit   = e_hit && (m_btb_kind[e_btb_idx] == nand_cpu_pkg::BR_COND);
        e_gidx       = m_hist ^ m_pc[INDEX_SIZE+1:2];
        e_fb_gidx    = m_hist ^ feedback.pc[INDEX_SIZE+1:2];
        e_taken      = (m_ctr[e_gidx] >= 2'd2);
        e_override   = e_hit && ((m_btb_kind[e_btb_idx] == nand_cpu_pkg::BR_JUMP) || e_taken);
        e_target     = m_btb_target[e_btb_idx];
        e_valid      = m_started && (m_credits > 0);
        e_redirect   = feedback_valid && feedback.mispredict;
        if (e_redirect) begin
            e_next_pc = feedback.next_pc;
        end else if (e_override) begin
            e_next_pc = e_target;
        end else begin
            e_next_pc = m_pc + 32'd4;
        end
    end

    always @(posedge clk) begin
        if (!n_rst) begin
            m_pc      <= nand_cpu_pkg::RESET_PC;
            m_started <= 1'b0;
            m_credits <= FETCH_CREDITS;
            m_hist    <= '0;
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                m_btb_valid[i] <= 1'b0;
            end
            for (int i = 0; i < 2**INDEX_SIZE; i++) begin
                m_ctr[i] <= 2'b01;
            end
        end else begin
            // first fetch issues one cycle after reset release
            m_started <= 1'b1;
            if (e_redirect || e_valid) begin
                m_pc <= e_next_pc;
            end
            if (e_valid && !credit_return) begin
                m_credits <= m_credits - 1;
            end else if (!e_valid && credit_return) begin
                m_credits <= m_credits + 1;
            end
            if (e_valid && e_cond_hit) begin
                m_hist <= {m_hist[INDEX_SIZE-2:0], e_taken};
            end
            if (feedback_valid) begin
                m_btb_valid[e_fb_btb_idx]  <= 1'b1;
                m_btb_kind[e_fb_btb_idx]   <= feedback.kind;
                m_btb_pc[e_fb_btb_idx]     <= feedback.pc;
                m_btb_target[e_fb_btb_idx] <= feedback.target;
                if (feedback.taken && (m_ctr[e_fb_gidx] != 2'd3)) begin
                    m_ctr[e_fb_gidx] <= m_ctr[e_fb_gidx] + 2'd1;
                end else if (!feedback.taken && (m_ctr[e_fb_gidx] != 2'd0)) begin
                    m_ctr[e_fb_gidx] <= m_ctr[e_fb_gidx] - 2'd1;
                end
            end
        end
    end

    // ========================================
    // checks
    // ========================================
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("%0t %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "%s", what);
    endtask

    assert property (@(posedge clk) !n_rst |=> !fetch_valid)
        else report_mismatch("fetch_valid", 32'd0, 32'($sampled(fetch_valid)));

    assert property (@(posedge clk) disable iff (!n_rst) fetch_valid == e_valid)
        else report_mismatch("fetch_valid", 32'($sampled(e_valid)), 32'($sampled(fetch_valid)));

    assert property (@(posedge clk) disable iff (!n_rst) fetch.pc == m_pc)
        else report_mismatch("fetch.pc", $sampled(m_pc), $sampled(fetch.pc));

    assert property (@(posedge clk) disable iff (!n_rst)
        fetch_valid |-> (fetch.pred_override == e_override))
        else report_mismatch("fetch.pred_override", 32'($sampled(e_override)),
                             32'($sampled(fetch.pred_override)));

    assert property (@(posedge clk) disable iff (!n_rst)
        (fetch_valid && e_override) |-> (fetch.pred_target == e_target))
        else report_mismatch("fetch.pred_target", $sampled(e_target),
                             $sampled(fetch.pred_target));

    assert property (@(posedge clk) disable iff (!n_rst) outstanding <= FETCH_CREDITS)
        else abort_run("more packets outstanding than the queue has slots");

    // ========================================
    // stimulus
    // ========================================

    // consumer returns credits in order after 0 to 3 cycles
    task automatic next_cycle();
        int delay;
        int due;
        @(negedge clk);
        tick++;
        feedback_valid = 1'b0;
        credit_return  = 1'b0;
        if (!hold && (due_q.size() > 0) && (due_q[0] <= tick)) begin
            void'(due_q.pop_front());
            credit_return = 1'b1;
            outstanding--;
        end
        if (n_rst && fetch_valid) begin
            delay = $random(seed) & 3;
            due   = tick + 1 + delay;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
            outstanding++;
        end
    endtask

    task automatic send_feedback(input logic [31:0] pc, input logic [31:0] target,
                                 input nand_cpu_pkg::branch_kind_e kind, input logic taken,
                                 input logic mispredict, input logic [31:0] next_pc);
        feedback_valid      = 1'b1;
        feedback.pc         = pc;
        feedback.target     = target;
        feedback.kind       = kind;
        feedback.taken      = taken;
        feedback.mispredict = mispredict;
        feedback.next_pc    = next_pc;
    endtask

    task automatic wait_packet_at(input logic [31:0] pc);
        do begin
            next_cycle();
        end while (!(fetch_valid && (fetch.pc == pc)));
    endtask

    initial begin
        n_rst          = 1'b0;
        feedback_valid = 1'b0;
        feedback       = '0;
        credit_return  = 1'b0;
        hold           = 1'b0;
        tick           = 0;
        last_due       = 0;
        outstanding    = 0;
        repeat (8) next_cycle();
        n_rst = 1'b1;

        // sequential fetch from the reset pc
        repeat (12) next_cycle();

        // withhold credits until the front end stalls
        hold = 1'b1;
        do begin
            next_cycle();
        end while (fetch_valid);
        repeat (6) next_cycle();
        hold = 1'b0;

        // jump entry written ahead of the fetch stream
        next_cycle();
        send_feedback(JUMP_PC, JUMP_TGT, nand_cpu_pkg::BR_JUMP, 1'b1, 1'b0, JUMP_TGT);
        wait_packet_at(JUMP_PC);
        wait_packet_at(JUMP_TGT);

        // small loop around a conditional branch
        next_cycle();
        send_feedback(OTHER_PC, COND_TGT, nand_cpu_pkg::BR_JUMP, 1'b1, 1'b1, COND_TGT);
        for (int i = 0; i < 10; i++) begin
            wait_packet_at(COND_PC);
            send_feedback(COND_PC, COND_TGT, nand_cpu_pkg::BR_COND, 1'b1,
                          !fetch.pred_override, COND_TGT);
        end

        // redirect against a jump override in the same cycle
        next_cycle();
        send_feedback(COND_PC, COND_TGT, nand_cpu_pkg::BR_COND, 1'b0, 1'b1, JUMP_PC - 32'd8);
        wait_packet_at(JUMP_PC);
        send_feedback(OTHER_PC, COND_TGT, nand_cpu_pkg::BR_JUMP, 1'b1, 1'b1, REDIRECT_PC);
        wait_packet_at(REDIRECT_PC);
        repeat (10) next_cycle();

        $display("** PASS **");
        $finish;
    end

    initial begin
        #((SCRIPT_CYCLES + 200) * CLK_PERIOD);
        $display("timeout: the fetch stream never reached the end of the test");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: verilog.f
common/nand_cpu_pkg.sv
branch_predictor/branch_target_buffer.sv
branch_predictor/branch_predictor_gshare.sv
branch_predictor/branch_predictor.sv
verilog/fetch_pc_gen.sv
verilog/fetch_frontend.sv
verification/fetch_frontend_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fetch_frontend_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
